// ==== verilog/psgBusPkg.sv ====
`default_nettype none

// ====================
// wave table bus types
// ====================

package psgBusPkg;

	// index into the 64 entry wave table
	typedef logic [5:0] waveAddr_t;

	// one wave sample, two's complement
	typedef logic signed [7:0] sample_t;

	// channel number, also the bus owner index
	typedef logic [2:0] chanIdx_t;

endpackage

`default_nettype wire

// ==== verilog/psgVoicePkg.sv ====
`default_nettype none

// ====================
// voice and mix types
// ====================

package psgVoicePkg;

	// phase accumulator, upper bits select the table entry
	typedef logic [15:0] phase_t;

	// phase step added on each sample tick
	typedef logic [15:0] freq_t;

	typedef logic [3:0] vol_t;

	// sample scaled by volume
	typedef logic signed [12:0] voice_t;

	typedef logic signed [15:0] mix_t;

endpackage

`default_nettype wire

// ==== verilog/psgBusArb.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgBusArb #(
	parameter int NumChannels = 8
) (
	input wire clk,
	input wire rst,
	input wire busCe,
	input wire ack,
	input wire [NumChannels-1:0] fetchReq,
	output logic [NumChannels-1:0] grant,
	output psgBusPkg::chanIdx_t busOwner
);

	logic [NumChannels-1:0] nextGrant;
	psgBusPkg::chanIdx_t nextOwner;

	// lowest numbered requester wins, so scan from the top down
	always_comb begin
		nextGrant = '0;
		nextOwner = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (fetchReq[i]) begin
				nextGrant = '0;
				nextGrant[i] = 1'b1;
				nextOwner = psgBusPkg::chanIdx_t'(i);
			end
		end
	end

	// re-arbitrate only on an enabled cycle with the transfer done
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			busOwner <= '0;
		end else if (busCe && ack && (|fetchReq)) begin
			grant <= nextGrant;
			busOwner <= nextOwner;
		end
		// no requester keeps the last owner on the bus
	end

endmodule

`default_nettype wire

// ==== verilog/psgWaveChannel.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgWaveChannel (
	input wire clk,
	input wire rst,
	input wire sampleTick,
	input wire cfgWe,
	input wire psgVoicePkg::freq_t cfgFreq,
	input wire psgVoicePkg::vol_t cfgVol,
	input wire cfgEnable,
	input wire grant,
	input wire dataValid,
	input wire psgBusPkg::sample_t readData,
	output logic fetchReq,
	output psgBusPkg::waveAddr_t fetchAddr,
	output psgVoicePkg::voice_t voice
);

	localparam int IdxBits = $bits(psgBusPkg::waveAddr_t);
	localparam int PhaseBits = $bits(psgVoicePkg::phase_t);

	psgVoicePkg::freq_t freq;
	psgVoicePkg::vol_t vol;
	logic enable;
	psgVoicePkg::phase_t phase;
	psgBusPkg::waveAddr_t lastIdx;
	logic sampleHeld;
	logic stepped;
	psgVoicePkg::voice_t voiceReg;
	logic capture;

	assign fetchAddr = phase[PhaseBits-1 -: IdxBits];
	// only take bus data that answers our own pending request
	assign capture = dataValid && grant && fetchReq;
	assign voice = enable ? voiceReg : '0;

	// ====================
	// settings and phase
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			phase <= '0;
			stepped <= 1'b0;
		end else if (cfgWe) begin
			freq <= cfgFreq;
			vol <= cfgVol;
			enable <= cfgEnable;
			phase <= '0;
			stepped <= 1'b0;
		end else begin
			stepped <= sampleTick && enable;
			if (sampleTick && enable) begin
				phase <= phase + freq;
			end
		end
	end

	// request a fetch the cycle after a step if the index moved
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchReq <= 1'b0;
			sampleHeld <= 1'b0;
		end else if (cfgWe) begin
			fetchReq <= 1'b0;
			sampleHeld <= 1'b0;
		end else if (capture) begin
			fetchReq <= 1'b0;
			sampleHeld <= 1'b1;
		end else if (stepped && ((fetchAddr != lastIdx) || !sampleHeld)) begin
			fetchReq <= 1'b1;
		end
	end

	// scaled sample, volume is zero extended before the multiply
	always_ff @(posedge clk) begin
		if (cfgWe) begin
			voiceReg <= '0;
		end else if (capture) begin
			voiceReg <= psgVoicePkg::voice_t'(readData) * psgVoicePkg::voice_t'(vol);
			lastIdx <= fetchAddr;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/psgWaveTable.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgWaveTable #(
	parameter int NumChannels = 8,
	parameter int ReadLatency = 2
) (
	input wire clk,
	input wire rst,
	input wire tblWe,
	input wire psgBusPkg::waveAddr_t tblAddr,
	input wire psgBusPkg::sample_t tblData,
	input wire [NumChannels-1:0] fetchReq,
	input wire psgBusPkg::waveAddr_t [NumChannels-1:0] fetchAddr,
	input wire psgBusPkg::chanIdx_t busOwner,
	output logic ack,
	output logic dataValid,
	output psgBusPkg::sample_t readData
);

	typedef enum logic [1:0] {Idle, Reading, Done} tblState_t;

	localparam int Depth = 2 ** $bits(psgBusPkg::waveAddr_t);

	psgBusPkg::sample_t mem [Depth];
	tblState_t state;
	logic [2:0] latCnt;
	psgBusPkg::waveAddr_t rdAddr;
	psgBusPkg::chanIdx_t rdChan;

	// ack is low only while a read is in flight
	assign ack = (state != Reading);
	assign dataValid = (state == Done);

	// host port, independent of the read side
	always_ff @(posedge clk) begin
		if (tblWe) begin
			mem[tblAddr] <= tblData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			latCnt <= '0;
		end else begin
			case (state)
				Idle: begin
					latCnt <= '0;
					if (fetchReq[busOwner]) begin
						state <= Reading;
					end
				end
				Reading: begin
					// requester withdrew, e.g. reconfigured mid-read
					if (!fetchReq[rdChan]) begin
						state <= Idle;
					end else if (latCnt == 3'(ReadLatency - 1)) begin
						state <= Done;
					end else begin
						latCnt <= latCnt + 3'd1;
					end
				end
				Done: state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	// latch the request at the start, read the array on the last cycle
	always_ff @(posedge clk) begin
		if (state == Idle && fetchReq[busOwner]) begin
			rdAddr <= fetchAddr[busOwner];
			rdChan <= busOwner;
		end
		if (state == Reading && latCnt == 3'(ReadLatency - 1)) begin
			readData <= mem[rdAddr];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/psgMixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgMixer #(
	parameter int NumChannels = 8
) (
	input wire clk,
	input wire rst,
	input wire sampleTick,
	input wire psgVoicePkg::voice_t [NumChannels-1:0] voices,
	output psgVoicePkg::mix_t mixOut
);

	psgVoicePkg::mix_t sum;

	// each voice is sign extended to the mix width before adding
	always_comb begin
		sum = '0;
		for (int i = 0; i < NumChannels; i++) begin
			sum = sum + psgVoicePkg::mix_t'($signed(voices[i]));
		end
	end

	// ====================
	// output register
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
		end else if (sampleTick) begin
			mixOut <= sum;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/psgTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgTop #(
	parameter int NumChannels = 8,
	parameter int ReadLatency = 2
) (
	input wire clk,
	input wire rst,
	input wire busCe,
	input wire sampleTick,
	input wire cfgWe,
	input wire psgBusPkg::chanIdx_t cfgChan,
	input wire psgVoicePkg::freq_t cfgFreq,
	input wire psgVoicePkg::vol_t cfgVol,
	input wire cfgEnable,
	input wire tblWe,
	input wire psgBusPkg::waveAddr_t tblAddr,
	input wire psgBusPkg::sample_t tblData,
	output psgVoicePkg::mix_t mixOut,
	output psgBusPkg::chanIdx_t busOwner,
	output logic [NumChannels-1:0] grant
);

	logic [NumChannels-1:0] fetchReq;
	psgBusPkg::waveAddr_t [NumChannels-1:0] fetchAddr;
	psgVoicePkg::voice_t [NumChannels-1:0] voices;
	logic ack;
	logic dataValid;
	psgBusPkg::sample_t readData;

	psgBusArb #(.NumChannels(NumChannels)) busArb_i (
		.clk(clk),
		.rst(rst),
		.busCe(busCe),
		.ack(ack),
		.fetchReq(fetchReq),
		.grant(grant),
		.busOwner(busOwner)
	);

	// one channel per slot, config strobe decoded by channel number
	for (genvar i = 0; i < NumChannels; i++) begin : gChan
		psgWaveChannel chan_i (
			.clk(clk),
			.rst(rst),
			.sampleTick(sampleTick),
			.cfgWe(cfgWe && (cfgChan == psgBusPkg::chanIdx_t'(i))),
			.cfgFreq(cfgFreq),
			.cfgVol(cfgVol),
			.cfgEnable(cfgEnable),
			.grant(grant[i]),
			.dataValid(dataValid),
			.readData(readData),
			.fetchReq(fetchReq[i]),
			.fetchAddr(fetchAddr[i]),
			.voice(voices[i])
		);
	end

	psgWaveTable #(.NumChannels(NumChannels), .ReadLatency(ReadLatency)) waveTable_i (
		.clk(clk),
		.rst(rst),
		.tblWe(tblWe),
		.tblAddr(tblAddr),
		.tblData(tblData),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.busOwner(busOwner),
		.ack(ack),
		.dataValid(dataValid),
		.readData(readData)
	);

	psgMixer #(.NumChannels(NumChannels)) mixer_i (
		.clk(clk),
		.rst(rst),
		.sampleTick(sampleTick),
		.voices(voices),
		.mixOut(mixOut)
	);

endmodule

`default_nettype wire

// ==== tests/psgTop_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module psgTop_tb;

	localparam int NumChannels = 8;
	localparam int ReadLatency = 2;
	localparam int TickPeriod = 64;
	localparam int NumRows = 10;
	localparam int MaxTicks = 66;
	localparam int TimeoutCycles = NumRows * MaxTicks * TickPeriod + 200;

	// each row holds channel, frequency, volume, enable, ticks and the last mixOut
	int rows [NumRows][6] = '{
		'{0, 0, 0, 0, 2, 0},
		'{3, 0, 5, 1, 2, -640},
		'{5, 0, 1, 1, 0, 0},
		'{2, 512, 2, 1, 0, 0},
		'{7, 0, 3, 1, 3, -1400},
		'{5, 0, 0, 0, 1, -1272},
		'{2, 0, 0, 0, 0, 0},
		'{3, 0, 0, 0, 0, 0},
		'{7, 0, 0, 0, 0, 0},
		'{6, 1024, 7, 1, 66, -868}
	};

	logic clk = 1'b0;
	logic rst;
	logic busCe;
	logic sampleTick;
	logic cfgWe;
	psgBusPkg::chanIdx_t cfgChan;
	psgVoicePkg::freq_t cfgFreq;
	psgVoicePkg::vol_t cfgVol;
	logic cfgEnable;
	logic tblWe;
	psgBusPkg::waveAddr_t tblAddr;
	psgBusPkg::sample_t tblData;
	psgVoicePkg::mix_t mixOut;
	psgBusPkg::chanIdx_t busOwner;
	logic [NumChannels-1:0] grant;

	// reference model of each channel's voice state
	int mdlEn [NumChannels];
	int mdlFreq [NumChannels];
	int mdlVol [NumChannels];
	int mdlPhase [NumChannels];
	int mdlHeld [NumChannels];
	int mdlIdx [NumChannels];
	int mdlVoice [NumChannels];
	int expOwner = 0;
	bit everGranted = 1'b0;
	int cycles = 0;
	int seed = 82833;

	psgTop #(.NumChannels(NumChannels), .ReadLatency(ReadLatency)) psgTop_i (
		.clk(clk),
		.rst(rst),
		.busCe(busCe),
		.sampleTick(sampleTick),
		.cfgWe(cfgWe),
		.cfgChan(cfgChan),
		.cfgFreq(cfgFreq),
		.cfgVol(cfgVol),
		.cfgEnable(cfgEnable),
		.tblWe(tblWe),
		.tblAddr(tblAddr),
		.tblData(tblData),
		.mixOut(mixOut),
		.busOwner(busOwner),
		.grant(grant)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("timeout: the tests did not finish within %0d cycles",
				TimeoutCycles);
			$display("Verification failed");
			$fatal(1);
		end
	end

	// ====================
	// helpers
	// ====================

	// ramp contents of the wave table
	function automatic int tableValue(input int idx);
		return 4 * idx - 128;
	endfunction

	task automatic expectTrue(input bit ok, input string what);
		assert (ok) else begin
			$display("Fail %0t: %s", $time, what);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// inputs move 10 ns after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#10;
	endtask

	task automatic writeConfig(input int chan, input int freq, input int vol, input int en);
		cfgWe = 1'b1;
		cfgChan = psgBusPkg::chanIdx_t'(chan);
		cfgFreq = psgVoicePkg::freq_t'(freq);
		cfgVol = psgVoicePkg::vol_t'(vol);
		cfgEnable = (en != 0);
		nextCycle();
		cfgWe = 1'b0;
		mdlEn[chan] = en;
		mdlFreq[chan] = freq;
		mdlVol[chan] = vol;
		mdlPhase[chan] = 0;
		mdlHeld[chan] = 0;
		mdlVoice[chan] = 0;
	endtask

	// one sample tick and the fetch round that follows it
	task automatic runTick();
		int expMix;
		int idx;
		int prev;
		int order [$];
		int want [$];
		int seen [$];
		psgBusPkg::chanIdx_t last;
		logic [NumChannels-1:0] expGrant;
		expMix = 0;
		for (int c = 0; c < NumChannels; c++) begin
			if (mdlEn[c] != 0) begin
				expMix += mdlVoice[c];
				mdlPhase[c] = (mdlPhase[c] + mdlFreq[c]) % 65536;
				idx = mdlPhase[c] / 1024;
				// ascending scan gives the fixed priority order
				if (mdlHeld[c] == 0 || idx != mdlIdx[c]) begin
					order.push_back(c);
					mdlHeld[c] = 1;
					mdlIdx[c] = idx;
					mdlVoice[c] = tableValue(idx) * mdlVol[c];
				end
			end
		end
		prev = expOwner;
		foreach (order[i]) begin
			if (order[i] != prev) begin
				want.push_back(order[i]);
			end
			prev = order[i];
		end
		last = busOwner;
		sampleTick = 1'b1;
		nextCycle();
		sampleTick = 1'b0;
		expectTrue(mixOut == psgVoicePkg::mix_t'(expMix),
			$sformatf("mixOut %0d, expected %0d", mixOut, expMix));
		for (int n = 1; n < TickPeriod; n++) begin
			if (busOwner != last) begin
				seen.push_back(int'(busOwner));
				last = busOwner;
			end
			nextCycle();
		end
		expectTrue(seen.size() == want.size(),
			$sformatf("%0d owner changes, expected %0d", seen.size(), want.size()));
		foreach (want[i]) begin
			expectTrue(seen[i] == want[i],
				$sformatf("owner change %0d is %0d, expected %0d", i, seen[i], want[i]));
		end
		if (order.size() > 0) begin
			expOwner = order[order.size() - 1];
			everGranted = 1'b1;
		end
		expGrant = everGranted ? (NumChannels'(1) << expOwner) : '0;
		expectTrue(busOwner == psgBusPkg::chanIdx_t'(expOwner),
			$sformatf("busOwner %0d, expected %0d", busOwner, expOwner));
		expectTrue(grant == expGrant,
			$sformatf("grant %b, expected %b", grant, expGrant));
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		rst = 1'b1;
		busCe = 1'b1;
		sampleTick = 1'b0;
		cfgWe = 1'b0;
		cfgChan = '0;
		cfgFreq = '0;
		cfgVol = '0;
		cfgEnable = 1'b0;
		tblWe = 1'b0;
		tblAddr = '0;
		tblData = '0;
		for (int c = 0; c < NumChannels; c++) begin
			mdlEn[c] = 0;
			mdlVoice[c] = 0;
		end
		repeat (16) nextCycle();
		rst = 1'b0;
		expectTrue(mixOut == '0 && busOwner == '0 && grant == '0,
			"outputs not cleared by reset");

		for (int i = 0; i < 64; i++) begin
			tblWe = 1'b1;
			tblAddr = psgBusPkg::waveAddr_t'(i);
			tblData = psgBusPkg::sample_t'(tableValue(i));
			nextCycle();
		end
		tblWe = 1'b0;

		for (int r = 0; r < NumRows; r++) begin
			// host write lands at a varying point between ticks
			repeat ({$random(seed)} % 8) nextCycle();
			writeConfig(rows[r][0], rows[r][1], rows[r][2], rows[r][3]);
			for (int t = 0; t < rows[r][4]; t++) begin
				runTick();
			end
			if (rows[r][4] > 0) begin
				expectTrue(mixOut == psgVoicePkg::mix_t'(rows[r][5]),
					$sformatf("row %0d mixOut %0d, expected %0d", r, mixOut, rows[r][5]));
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== psg.f ====
verilog/psgBusPkg.sv
verilog/psgVoicePkg.sv
verilog/psgBusArb.sv
verilog/psgWaveChannel.sv
verilog/psgWaveTable.sv
verilog/psgMixer.sv
verilog/psgTop.sv
tests/psgTop_tb.sv

// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = psgTop_tb
FILELIST = psg.f

.PHONY: sim clean

# the run passes only if the pass message shows up in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
